// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// ----------------------------------------------------------------------
	// Widths
	// ----------------------------------------------------------------------

	// Processor address, top bit selects the uncached I/O window
	localparam int addr_width = 28;
	localparam int data_width = 32;
	localparam int words_per_block = 8;
	localparam int block_width = words_per_block * data_width;

	// Word offset inside a block
	localparam int offset_width = $clog2(words_per_block);

	// Address bit that routes a request to the I/O port
	localparam int io_bit = addr_width - 1;

	// ----------------------------------------------------------------------
	// Request types
	// ----------------------------------------------------------------------

	// Processor request, held stable until cpu_ready
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
		logic                  write;
	} cpu_req_t;

	// Block request towards memory, offset bits always zero
	typedef struct packed {
		logic [addr_width-1:0]  addr;
		logic [block_width-1:0] wblock;
		logic                   write;
	} mem_req_t;

	// I/O side sees the processor request unchanged
	typedef cpu_req_t io_req_t;

	// ----------------------------------------------------------------------
	// Controller FSM
	// ----------------------------------------------------------------------

	typedef enum logic [2:0] {
		idle,
		compare_tag,
		write_back,
		allocate,
		allocate_wait,
		flush_scan,
		flush_write
	} cache_state_e;

endpackage

`default_nettype wire

// ==== cache/cache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
	parameter int index_width = 10,
	localparam int tag_width = cache_pkg::addr_width - 1 - index_width
		- cache_pkg::offset_width
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [index_width-1:0]            index,
	input  logic [tag_width-1:0]              lookup_tag,
	input  logic                              write_en,
	input  logic [tag_width-1:0]              write_tag,
	input  logic [cache_pkg::block_width-1:0] write_block,
	input  logic                              write_valid,
	input  logic                              write_dirty,
	input  logic                              lru_write_en,
	input  logic                              lru_value,
	output logic                              hit,
	output logic                              valid,
	output logic                              dirty,
	output logic [tag_width-1:0]              tag,
	output logic [cache_pkg::block_width-1:0] block,
	output logic                              lru
);

	import cache_pkg::*;

	localparam int num_sets = 1 << index_width;

	logic [tag_width-1:0]   tag_mem   [num_sets];
	logic [block_width-1:0] block_mem [num_sets];
	logic                   dirty_mem [num_sets];

	// Valid and LRU bits as flat vectors so reset clears them at once
	logic [num_sets-1:0] valid_q;
	logic [num_sets-1:0] lru_q;

	// ----------------------------------------------------------------------
	// Lookup, combinational from the index
	// ----------------------------------------------------------------------

	assign valid = valid_q[index];
	assign dirty = dirty_mem[index];
	assign tag = tag_mem[index];
	assign block = block_mem[index];
	assign lru = lru_q[index];
	assign hit = valid_q[index] && (tag_mem[index] == lookup_tag);

	// ----------------------------------------------------------------------
	// Write port
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (write_en) begin
			tag_mem[index] <= write_tag;
			block_mem[index] <= write_block;
			dirty_mem[index] <= write_dirty;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (write_en) begin
			valid_q[index] <= write_valid;
		end
	end

	// Only meaningful in way 0, the other way gets a tied-off strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lru_q <= '0;
		end else if (lru_write_en) begin
			lru_q[index] <= lru_value;
		end
	end

	// Controller decode must never leave the write strobe floating
	assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(write_en))
		else $error("cache_way: write_en is unknown");

endmodule

`default_nettype wire

// ==== cache/cache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
	parameter int index_width = 10,
	localparam int tag_width = cache_pkg::addr_width - 1 - index_width
		- cache_pkg::offset_width
) (
	input  logic                                    clk,
	input  logic                                    rst_n,

	// Processor side
	input  cache_pkg::cpu_req_t                     cpu_req,
	input  logic                                    cpu_valid,
	input  logic                                    cpu_flush,
	output logic [cache_pkg::data_width-1:0]        cpu_rdata,
	output logic                                    cpu_ready,

	// Memory side
	output cache_pkg::mem_req_t                     mem_req,
	output logic                                    mem_valid,
	input  logic [cache_pkg::block_width-1:0]       mem_rblock,
	input  logic                                    mem_ready,

	// Uncached I/O side
	output cache_pkg::io_req_t                      io_req,
	output logic                                    io_valid,
	input  logic [cache_pkg::data_width-1:0]        io_rdata,
	input  logic                                    io_ready,

	// Way storage, shared read/write port plus per-way strobes
	output logic [index_width-1:0]                  way_index,
	output logic [tag_width-1:0]                    way_lookup_tag,
	output logic [1:0]                              way_write_en,
	output logic [tag_width-1:0]                    way_write_tag,
	output logic [cache_pkg::block_width-1:0]       way_write_block,
	output logic                                    way_write_valid,
	output logic                                    way_write_dirty,
	output logic                                    way_lru_write_en,
	output logic                                    way_lru_value,
	input  logic [1:0]                              way_hit,
	input  logic [1:0]                              way_valid,
	input  logic [1:0]                              way_dirty,
	input  logic [1:0][tag_width-1:0]               way_tag,
	input  logic [1:0][cache_pkg::block_width-1:0]  way_block,
	input  logic                                    way_lru
);

	import cache_pkg::*;

	cache_state_e state_q;
	cache_state_e state_d;

	// Flush walk position and completion pulse
	logic [index_width-1:0] flush_set_q;
	logic                   flush_way_q;
	logic                   flush_done_q;

	logic [tag_width-1:0]    req_tag;
	logic [index_width-1:0]  req_index;
	logic [offset_width-1:0] req_offset;
	logic                    io_sel;
	logic                    in_flush;
	logic                    hit_any;
	logic                    victim_dirty;
	logic                    flush_line_dirty;
	logic                    flush_last;
	logic                    flush_step;
	logic                    sel_way;
	logic [tag_width-1:0]    line_tag;
	logic [block_width-1:0]  sel_block;
	logic [block_width-1:0]  merged_block;
	logic [data_width-1:0]   cache_rdata;
	logic                    cache_ready;

	// ----------------------------------------------------------------------
	// Address split and I/O bypass
	// ----------------------------------------------------------------------

	assign req_offset = cpu_req.addr[offset_width-1:0];
	assign req_index = cpu_req.addr[offset_width +: index_width];
	assign req_tag = cpu_req.addr[offset_width + index_width +: tag_width];

	// Flush wins over the I/O window
	assign io_sel = cpu_req.addr[io_bit] && !cpu_flush;
	assign io_req = cpu_req;
	assign io_valid = cpu_valid && io_sel;

	// ----------------------------------------------------------------------
	// Way selection
	// ----------------------------------------------------------------------

	assign in_flush = (state_q == flush_scan) || (state_q == flush_write);
	assign hit_any = |way_hit;

	// Stored LRU bit names the way to replace
	assign victim_dirty = way_valid[way_lru] && way_dirty[way_lru];
	assign flush_line_dirty = way_valid[flush_way_q] && way_dirty[flush_way_q];
	assign flush_last = flush_way_q && (&flush_set_q);
	assign flush_step = ((state_q == flush_scan) && !flush_line_dirty)
		|| ((state_q == flush_write) && mem_ready);

	always_comb begin
		case (state_q)
			compare_tag: sel_way = way_hit[1];
			flush_scan, flush_write: sel_way = flush_way_q;
			default: sel_way = way_lru;
		endcase
	end

	assign sel_block = way_block[sel_way];
	assign way_index = in_flush ? flush_set_q : req_index;
	assign way_lookup_tag = req_tag;

	// Word read and write merge at the request offset
	assign cache_rdata = sel_block[req_offset*data_width +: data_width];

	always_comb begin
		merged_block = sel_block;
		merged_block[req_offset*data_width +: data_width] = cpu_req.wdata;
	end

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			idle: begin
				// Hold off one cycle while the flush ready pulse is out
				if (cpu_valid && !flush_done_q) begin
					if (cpu_flush) begin
						state_d = flush_scan;
					end else if (!io_sel) begin
						state_d = compare_tag;
					end
				end
			end
			compare_tag: begin
				if (hit_any) begin
					state_d = idle;
				end else if (victim_dirty) begin
					state_d = write_back;
				end else begin
					state_d = allocate;
				end
			end
			write_back: begin
				if (mem_ready) begin
					state_d = allocate;
				end
			end
			allocate: begin
				if (mem_ready) begin
					state_d = allocate_wait;
				end
			end
			allocate_wait: state_d = compare_tag;
			flush_scan: begin
				if (flush_line_dirty) begin
					state_d = flush_write;
				end else if (flush_last) begin
					state_d = idle;
				end
			end
			flush_write: begin
				if (mem_ready) begin
					state_d = flush_last ? idle : flush_scan;
				end
			end
			default: state_d = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= idle;
			flush_set_q <= '0;
			flush_way_q <= 1'b0;
			flush_done_q <= 1'b0;
		end else begin
			state_q <= state_d;
			flush_done_q <= flush_step && flush_last;
			// Way 0 then way 1 of each set, wraps back to zero at the end
			if (flush_step) begin
				flush_way_q <= !flush_way_q;
				if (flush_way_q) begin
					flush_set_q <= flush_set_q + 1'b1;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// Way writes and LRU update
	// ----------------------------------------------------------------------

	always_comb begin
		way_write_en = 2'b00;
		way_write_tag = way_tag[sel_way];
		way_write_block = sel_block;
		way_write_valid = 1'b1;
		way_write_dirty = 1'b0;
		way_lru_write_en = 1'b0;
		// Point LRU away from the way just used
		way_lru_value = !sel_way;
		case (state_q)
			compare_tag: begin
				if (hit_any) begin
					way_lru_write_en = 1'b1;
					if (cpu_req.write) begin
						way_write_en[sel_way] = 1'b1;
						way_write_block = merged_block;
						way_write_dirty = 1'b1;
					end
				end
			end
			allocate: begin
				if (mem_ready) begin
					way_write_en[sel_way] = 1'b1;
					way_write_tag = req_tag;
					way_write_block = mem_rblock;
					way_lru_write_en = 1'b1;
				end
			end
			flush_scan, flush_write: begin
				if (flush_step) begin
					way_write_en[sel_way] = 1'b1;
					way_write_valid = 1'b0;
				end
			end
			default: ;
		endcase
	end

	// ----------------------------------------------------------------------
	// Memory and processor outputs
	// ----------------------------------------------------------------------

	assign line_tag = (state_q == allocate) ? req_tag : way_tag[sel_way];

	always_comb begin
		mem_req.addr = {1'b0, line_tag, way_index, {offset_width{1'b0}}};
		mem_req.wblock = sel_block;
		mem_req.write = (state_q != allocate);
	end

	assign mem_valid = (state_q == write_back) || (state_q == allocate)
		|| (state_q == flush_write);

	assign cache_ready = ((state_q == compare_tag) && hit_any) || flush_done_q;
	assign cpu_ready = io_sel ? io_ready : cache_ready;
	assign cpu_rdata = io_sel ? io_rdata : cache_rdata;

	// Memory side sees a steady request until it answers
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
		else $error("cache_controller: mem_req changed while waiting");

	// A block never lives in both ways of a set
	assert property (@(posedge clk) disable iff (!rst_n) !(way_hit[0] && way_hit[1]))
		else $error("cache_controller: both ways hit");

	assert property (@(posedge clk) disable iff (!rst_n) cpu_ready |=> !cpu_ready)
		else $error("cache_controller: cpu_ready longer than one cycle");

endmodule

`default_nettype wire

// ==== design/cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem #(
	parameter int index_width = 10,
	localparam int tag_width = cache_pkg::addr_width - 1 - index_width
		- cache_pkg::offset_width
) (
	input  logic                              clk,
	input  logic                              rst_n,
	// Processor side
	input  cache_pkg::cpu_req_t               cpu_req,
	input  logic                              cpu_valid,
	input  logic                              cpu_flush,
	output logic [cache_pkg::data_width-1:0]  cpu_rdata,
	output logic                              cpu_ready,
	// Memory side
	output cache_pkg::mem_req_t               mem_req,
	output logic                              mem_valid,
	input  logic [cache_pkg::block_width-1:0] mem_rblock,
	input  logic                              mem_ready,
	// I/O side
	output cache_pkg::io_req_t                io_req,
	output logic                              io_valid,
	input  logic [cache_pkg::data_width-1:0]  io_rdata,
	input  logic                              io_ready
);

	import cache_pkg::*;

	logic [index_width-1:0]           way_index;
	logic [tag_width-1:0]             way_lookup_tag;
	logic [1:0]                       way_write_en;
	logic [tag_width-1:0]             way_write_tag;
	logic [block_width-1:0]           way_write_block;
	logic                             way_write_valid;
	logic                             way_write_dirty;
	logic                             way_lru_write_en;
	logic                             way_lru_value;
	logic [1:0]                       way_hit;
	logic [1:0]                       way_valid;
	logic [1:0]                       way_dirty;
	logic [1:0][tag_width-1:0]        way_tag;
	logic [1:0][block_width-1:0]      way_block;
	logic                             way_lru;

	cache_controller #(
		.index_width(index_width)
	) u_controller (
		.clk              (clk),
		.rst_n            (rst_n),
		.cpu_req          (cpu_req),
		.cpu_valid        (cpu_valid),
		.cpu_flush        (cpu_flush),
		.cpu_rdata        (cpu_rdata),
		.cpu_ready        (cpu_ready),
		.mem_req          (mem_req),
		.mem_valid        (mem_valid),
		.mem_rblock       (mem_rblock),
		.mem_ready        (mem_ready),
		.io_req           (io_req),
		.io_valid         (io_valid),
		.io_rdata         (io_rdata),
		.io_ready         (io_ready),
		.way_index        (way_index),
		.way_lookup_tag   (way_lookup_tag),
		.way_write_en     (way_write_en),
		.way_write_tag    (way_write_tag),
		.way_write_block  (way_write_block),
		.way_write_valid  (way_write_valid),
		.way_write_dirty  (way_write_dirty),
		.way_lru_write_en (way_lru_write_en),
		.way_lru_value    (way_lru_value),
		.way_hit          (way_hit),
		.way_valid        (way_valid),
		.way_dirty        (way_dirty),
		.way_tag          (way_tag),
		.way_block        (way_block),
		.way_lru          (way_lru)
	);

	// Way 0 also carries the per-set LRU bit
	cache_way #(
		.index_width(index_width)
	) way0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.index        (way_index),
		.lookup_tag   (way_lookup_tag),
		.write_en     (way_write_en[0]),
		.write_tag    (way_write_tag),
		.write_block  (way_write_block),
		.write_valid  (way_write_valid),
		.write_dirty  (way_write_dirty),
		.lru_write_en (way_lru_write_en),
		.lru_value    (way_lru_value),
		.hit          (way_hit[0]),
		.valid        (way_valid[0]),
		.dirty        (way_dirty[0]),
		.tag          (way_tag[0]),
		.block        (way_block[0]),
		.lru          (way_lru)
	);

	cache_way #(
		.index_width(index_width)
	) way1 (
		.clk          (clk),
		.rst_n        (rst_n),
		.index        (way_index),
		.lookup_tag   (way_lookup_tag),
		.write_en     (way_write_en[1]),
		.write_tag    (way_write_tag),
		.write_block  (way_write_block),
		.write_valid  (way_write_valid),
		.write_dirty  (way_write_dirty),
		.lru_write_en (1'b0),
		.lru_value    (1'b0),
		.hit          (way_hit[1]),
		.valid        (way_valid[1]),
		.dirty        (way_dirty[1]),
		.tag          (way_tag[1]),
		.block        (way_block[1]),
		.lru          ()
	);

endmodule

`default_nettype wire

// ==== test/cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
	input  logic                             clk,
	input  logic                             rst_n,
	input  cache_pkg::cpu_req_t              cpu_req,
	input  logic                             cpu_valid,
	input  logic                             cpu_flush,
	input  logic [cache_pkg::data_width-1:0] cpu_rdata,
	input  logic                             cpu_ready,
	input  cache_pkg::mem_req_t              mem_req,
	input  logic                             mem_valid,
	input  logic                             mem_ready,
	input  cache_pkg::io_req_t               io_req,
	input  logic                             io_valid,
	input  logic                             io_ready,
	input  logic                             expect_hit,
	input  logic                             expect_miss,
	output int                               error_count
);

	import cache_pkg::*;

	localparam int busy_limit = 300;

	// Latest value of every word written by the processor
	logic [data_width-1:0] shadow [logic [addr_width-1:0]];
	// Blocks whose newest data lives only in the cache
	bit                    dirty_blocks [logic [addr_width-1:0]];
	int                    busy_cycles;
	int                    flush_expected;
	int                    flush_writes;
	bit                    ready_prev;

	function automatic logic [data_width-1:0] shadow_word(input logic [addr_width-1:0] addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return {4'h0, addr} ^ 32'h5a5a_0000;
	endfunction

	task automatic fail_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("FAIL %s expected %0h actual %0h at %0t", name, expected, actual, $time);
		error_count++;
	endtask

	task automatic fail_text(input string what);
		$display("Error at %0t: %s", $time, what);
		error_count++;
	endtask

	// ----------------------------------------------------------------------
	// Write-back and request completion
	// ----------------------------------------------------------------------

	task automatic check_mem_write();
		logic [addr_width-1:0] blk;
		logic [data_width-1:0] word;
		blk = mem_req.addr;
		if (blk[offset_width-1:0] != '0) begin
			fail_value("mem_req.addr", 64'(blk & ~addr_width'(words_per_block - 1)), 64'(blk));
		end
		if (dirty_blocks.exists(blk)) begin
			dirty_blocks.delete(blk);
		end else begin
			fail_text($sformatf("write-back of block %h, which holds no new data", blk));
		end
		for (int i = 0; i < words_per_block; i++) begin
			word = mem_req.wblock[i*data_width +: data_width];
			if (word !== shadow_word(blk + addr_width'(i))) begin
				fail_value($sformatf("mem_req.wblock word %0d", i),
					64'(shadow_word(blk + addr_width'(i))), 64'(word));
			end
		end
		if (cpu_valid && cpu_flush) begin
			flush_writes++;
		end
	endtask

	task automatic finish_request();
		logic [addr_width-1:0] addr;
		logic [addr_width-1:0] blk;
		addr = cpu_req.addr;
		blk = {addr[addr_width-1:offset_width], {offset_width{1'b0}}};
		if (cpu_flush) begin
			if (flush_writes != flush_expected) begin
				fail_value("mem write count", 64'(flush_expected), 64'(flush_writes));
			end
			if (dirty_blocks.num() != 0) begin
				fail_text("dirty blocks remain after the flush");
			end
		end else if (addr[io_bit]) begin
			if (!cpu_req.write && cpu_rdata !== ({4'h0, addr} ^ 32'h0f0f_0f0f)) begin
				fail_value("cpu_rdata", 64'({4'h0, addr} ^ 32'h0f0f_0f0f), 64'(cpu_rdata));
			end
		end else begin
			if (expect_hit && busy_cycles != 2) begin
				fail_value("cpu_ready latency", 64'(2), 64'(busy_cycles));
			end
			if (expect_miss && busy_cycles <= 2) begin
				fail_text($sformatf("access to %h hit, a miss was expected", addr));
			end
			if (cpu_req.write) begin
				shadow[addr] = cpu_req.wdata;
				dirty_blocks[blk] = 1'b1;
			end else if (cpu_rdata !== shadow_word(addr)) begin
				fail_value("cpu_rdata", 64'(shadow_word(addr)), 64'(cpu_rdata));
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			// Flush starts with the dirty count known so far
			if (cpu_valid && busy_cycles == 0 && cpu_flush) begin
				flush_expected = dirty_blocks.num();
				flush_writes = 0;
			end
			if (cpu_ready && !cpu_valid) begin
				fail_text("cpu_ready pulsed with no request pending");
			end
			if (cpu_ready && ready_prev) begin
				fail_text("cpu_ready stayed high for two cycles");
			end
			ready_prev = cpu_ready;
			if (mem_valid && mem_ready && mem_req.write) begin
				check_mem_write();
			end
			if (cpu_valid && cpu_req.addr[io_bit] && !cpu_flush) begin
				if (io_valid !== 1'b1) begin
					fail_value("io_valid", 64'(1), 64'(io_valid));
				end
				if (io_req !== cpu_req) begin
					fail_value("io_req", 64'(cpu_req), 64'(io_req));
				end
				if (cpu_ready !== io_ready) begin
					fail_value("cpu_ready", 64'(io_ready), 64'(cpu_ready));
				end
				if (mem_valid) begin
					fail_text("memory request during an I/O access");
				end
			end else if (io_valid) begin
				fail_text("io_valid raised outside the I/O window");
			end
			if (cpu_valid) begin
				busy_cycles++;
				if (busy_cycles == busy_limit) begin
					fail_text("request still waiting for cpu_ready");
				end
				if (cpu_ready) begin
					finish_request();
					busy_cycles = 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

	import cache_pkg::*;

	localparam int index_width = 4;
	localparam int ready_timeout = 400;

	typedef enum logic [1:0] {op_read, op_write, op_flush} op_e;
	typedef enum logic [1:0] {lat_any, lat_hit, lat_miss} lat_e;

	typedef struct packed {
		op_e                   op;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
		lat_e                  lat;
	} step_t;

	logic                   clk;
	logic                   rst_n;
	cpu_req_t               cpu_req;
	logic                   cpu_valid;
	logic                   cpu_flush;
	logic [data_width-1:0]  cpu_rdata;
	logic                   cpu_ready;
	mem_req_t               mem_req;
	logic                   mem_valid;
	logic [block_width-1:0] mem_rblock;
	logic                   mem_ready;
	io_req_t                io_req;
	logic                   io_valid;
	logic [data_width-1:0]  io_rdata;
	logic                   io_ready;
	logic                   expect_hit;
	logic                   expect_miss;
	int                     checker_errors;
	int                     driver_errors;

	// Memory model, one entry per written block
	logic [block_width-1:0] mem_blocks [logic [addr_width-1:0]];
	step_t                  steps [$];

	cache_subsystem #(
		.index_width(index_width)
	) dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_req    (cpu_req),
		.cpu_valid  (cpu_valid),
		.cpu_flush  (cpu_flush),
		.cpu_rdata  (cpu_rdata),
		.cpu_ready  (cpu_ready),
		.mem_req    (mem_req),
		.mem_valid  (mem_valid),
		.mem_rblock (mem_rblock),
		.mem_ready  (mem_ready),
		.io_req     (io_req),
		.io_valid   (io_valid),
		.io_rdata   (io_rdata),
		.io_ready   (io_ready)
	);

	cache_checker chk (
		.clk         (clk),
		.rst_n       (rst_n),
		.cpu_req     (cpu_req),
		.cpu_valid   (cpu_valid),
		.cpu_flush   (cpu_flush),
		.cpu_rdata   (cpu_rdata),
		.cpu_ready   (cpu_ready),
		.mem_req     (mem_req),
		.mem_valid   (mem_valid),
		.mem_ready   (mem_ready),
		.io_req      (io_req),
		.io_valid    (io_valid),
		.io_ready    (io_ready),
		.expect_hit  (expect_hit),
		.expect_miss (expect_miss),
		.error_count (checker_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Blocks never written read back as word address xor a fixed pattern
	function automatic logic [block_width-1:0] read_block(input logic [addr_width-1:0] blk);
		logic [block_width-1:0] data;
		logic [addr_width-1:0]  word_addr;
		if (mem_blocks.exists(blk)) begin
			return mem_blocks[blk];
		end
		for (int i = 0; i < words_per_block; i++) begin
			word_addr = blk + addr_width'(i);
			data[i*data_width +: data_width] = {4'h0, word_addr} ^ 32'h5a5a_0000;
		end
		return data;
	endfunction

	task automatic serve_memory();
		int delay;
		forever begin
			@(posedge clk);
			if (rst_n && mem_valid) begin
				delay = $urandom_range(4, 1);
				repeat (delay) @(negedge clk);
				if (mem_req.write) begin
					mem_blocks[mem_req.addr] = mem_req.wblock;
				end else begin
					mem_rblock = read_block(mem_req.addr);
				end
				mem_ready = 1'b1;
				@(negedge clk);
				mem_ready = 1'b0;
			end
		end
	endtask

	task automatic serve_io();
		int delay;
		forever begin
			@(posedge clk);
			if (rst_n && io_valid) begin
				delay = $urandom_range(3, 1);
				repeat (delay) @(negedge clk);
				io_rdata = {4'h0, io_req.addr} ^ 32'h0f0f_0f0f;
				io_ready = 1'b1;
				@(negedge clk);
				io_ready = 1'b0;
			end
		end
	endtask

	task automatic add_step(input op_e op, input logic [addr_width-1:0] addr,
			input logic [data_width-1:0] wdata, input lat_e lat);
		steps.push_back(step_t'{op, addr, wdata, lat});
	endtask

	// ----------------------------------------------------------------------
	// Stimulus table
	// ----------------------------------------------------------------------

	task automatic build_table();
		// Read miss, then hits in the same block
		add_step(op_read, 28'h000_0010, 32'h0, lat_miss);
		add_step(op_read, 28'h000_0010, 32'h0, lat_hit);
		add_step(op_read, 28'h000_0013, 32'h0, lat_hit);
		// Write allocate, then read back from the cache
		add_step(op_write, 28'h000_0045, 32'hdead_beef, lat_miss);
		add_step(op_read, 28'h000_0045, 32'h0, lat_hit);
		add_step(op_write, 28'h000_0012, 32'h1234_5678, lat_hit);
		add_step(op_read, 28'h000_0012, 32'h0, lat_hit);
		// Set 3: A dirty, B and C push A out
		add_step(op_write, 28'h000_009a, 32'ha5a5_0001, lat_miss);
		add_step(op_read, 28'h000_011c, 32'h0, lat_miss);
		add_step(op_read, 28'h000_019c, 32'h0, lat_miss);
		add_step(op_read, 28'h000_009a, 32'h0, lat_miss);
		// Set 5: A, B, A, C must replace B
		add_step(op_read, 28'h000_0228, 32'h0, lat_miss);
		add_step(op_write, 28'h000_02a9, 32'h0000_b0b0, lat_miss);
		add_step(op_read, 28'h000_022c, 32'h0, lat_hit);
		add_step(op_read, 28'h000_032a, 32'h0, lat_miss);
		add_step(op_read, 28'h000_0228, 32'h0, lat_hit);
		add_step(op_read, 28'h000_02a9, 32'h0, lat_miss);
		// More dirty lines, then flush with the I/O bit set
		add_step(op_write, 28'h000_0031, 32'h3131_3131, lat_miss);
		add_step(op_write, 28'h000_004c, 32'h4c4c_0000, lat_miss);
		add_step(op_flush, 28'h800_0000, 32'h0, lat_any);
		add_step(op_read, 28'h000_0045, 32'h0, lat_miss);
		add_step(op_read, 28'h000_0012, 32'h0, lat_miss);
		add_step(op_read, 28'h000_0031, 32'h0, lat_miss);
		add_step(op_read, 28'h000_009a, 32'h0, lat_miss);
		add_step(op_read, 28'h000_02a9, 32'h0, lat_miss);
		add_step(op_read, 28'h000_0017, 32'h0, lat_hit);
		// Uncached window
		add_step(op_read, 28'h800_0123, 32'h0, lat_any);
		add_step(op_write, 28'h800_0200, 32'h0bad_cafe, lat_any);
		add_step(op_read, 28'h800_00ff, 32'h0, lat_any);
		add_step(op_write, 28'h000_0013, 32'h5555_aaaa, lat_hit);
		add_step(op_read, 28'h000_0013, 32'h0, lat_hit);
	endtask

	task automatic wait_ready(input logic [addr_width-1:0] addr, output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < ready_timeout) begin
			@(posedge clk);
			cycles++;
			if (cpu_ready) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			$display("Timeout: no cpu_ready within %0d cycles for address %h", cycles, addr);
			driver_errors++;
		end
	endtask

	task automatic finish_run();
		$display("Errors: checker %0d, testbench %0d", checker_errors, driver_errors);
		if (checker_errors == 0 && driver_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	initial begin
		step_t st;
		bit    ok;
		void'($urandom(32'h3931_64c8));
		rst_n = 1'b0;
		cpu_req = '0;
		cpu_valid = 1'b0;
		cpu_flush = 1'b0;
		mem_rblock = '0;
		mem_ready = 1'b0;
		io_rdata = '0;
		io_ready = 1'b0;
		expect_hit = 1'b0;
		expect_miss = 1'b0;
		driver_errors = 0;
		build_table();
		fork
			serve_memory();
			serve_io();
		join_none
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < steps.size(); i++) begin
			st = steps[i];
			@(negedge clk);
			cpu_req.addr = st.addr;
			cpu_req.wdata = st.wdata;
			cpu_req.write = (st.op == op_write);
			cpu_flush = (st.op == op_flush);
			expect_hit = (st.lat == lat_hit);
			expect_miss = (st.lat == lat_miss);
			cpu_valid = 1'b1;
			wait_ready(st.addr, ok);
			if (!ok) begin
				break;
			end
			@(negedge clk);
			cpu_valid = 1'b0;
			cpu_flush = 1'b0;
		end
		repeat (2) @(negedge clk);
		finish_run();
	end

endmodule

`default_nettype wire

// ==== build.f ====
common/cache_pkg.sv
cache/cache_way.sv
cache/cache_controller.sv
design/cache_subsystem.sv
test/cache_checker.sv
test/tb_cache.sv

// ==== Makefile ====
# Verilator simulation of the cache subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cache
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
